// File: flist.f
source/l2_cache_pkg.sv
source/l2_ctl_pkg.sv
source/l2_ctl_if.sv
source/l2_way.sv
source/l2_plru.sv
source/l2_cache_datapath.sv
source/l2_cache_control.sv
source/l2_cache.sv
verification/l2_mem_model.sv
verification/l2_cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module l2_cache_tb -f flist.f -o l2_cache_sim
./obj_dir/l2_cache_sim

// File: verification/l2_cache_tb.sv
module l2_cache_tb;

    localparam int num_ops     = 600;
    localparam int cycle_limit = num_ops * 20;

    logic         clk;
    logic         reset;
    logic         mem_read;
    logic         mem_write;
    logic         mem_resp;
    logic         pmem_read;
    logic         pmem_write;
    logic         pmem_resp;
    logic [15:0]  mem_address;
    logic [15:0]  pmem_address;
    logic [127:0] mem_wdata;
    logic [127:0] mem_rdata;
    logic [127:0] pmem_wdata;
    logic [127:0] pmem_rdata;

    integer       seed = 74731;
    int           cycle_count = 0;
    logic [127:0] ref_mem [4096];      // latest value of every line
    logic [8:0]   ref_tag [8][8];
    logic         ref_valid [8][8];
    logic         ref_dirty [8][8];
    logic [6:0]   ref_plru [8];

    l2_cache i_dut (.*);
    l2_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // tree walk where a 0 bit leads to the lower ways
    function automatic logic [2:0] plru_victim(input logic [6:0] bits);
        int         node;
        logic [2:0] way;
        node = 0;
        way  = 3'd0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            way  = {way[1:0], bits[node]};
            node = 2 * node + 1 + int'(bits[node]);
        end
        return way;
    endfunction

    function automatic logic [6:0] plru_touch(input logic [6:0] bits, input logic [2:0] way);
        int         node;
        logic [6:0] next;
        node = 0;
        next = bits;
        for (int lvl = 0; lvl < 3; lvl++) begin
            next[node] = ~way[2 - lvl];   // point away from the used way
            node       = 2 * node + 1 + int'(way[2 - lvl]);
        end
        return next;
    endfunction

    task automatic run_access(input logic is_write, input logic [15:0] addr,
                              input logic [127:0] data);
        logic [8:0]  tag;
        logic [2:0]  set;
        logic [11:0] line;
        logic [2:0]  way;
        logic        hit;
        logic        exp_wb;
        logic        saw_read;
        logic        saw_write;
        int          wait_cycles;
        tag  = addr[15:7];
        set  = addr[6:4];
        line = addr[15:4];
        hit  = 1'b0;
        way  = plru_victim(ref_plru[set]);
        for (int w = 0; w < 8; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = 3'(w);
            end
        end
        exp_wb      = !hit && ref_valid[set][way] && ref_dirty[set][way];
        saw_read    = 1'b0;
        saw_write   = 1'b0;
        wait_cycles = 0;
        mem_read    = !is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = data;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (pmem_write) begin
                assert (exp_wb && !saw_read) else report_error("unexpected write-back");
                assert (pmem_address == {ref_tag[set][way], set, 4'h0})
                    else report_error($sformatf("write-back address %h", pmem_address));
                assert (pmem_wdata == ref_mem[{ref_tag[set][way], set}])
                    else report_error($sformatf("write-back data %h", pmem_wdata));
                saw_write = 1'b1;
            end
            if (pmem_read) begin
                assert (!hit && (saw_write || !exp_wb)) else report_error("unexpected fill read");
                assert (pmem_address == {line, 4'h0})
                    else report_error($sformatf("fill address %h", pmem_address));
                saw_read = 1'b1;
            end
        end while (!mem_resp);
        assert (saw_read == !hit && saw_write == exp_wb)
            else report_error($sformatf("memory traffic wrong for address %h", addr));
        if (hit) begin
            assert (wait_cycles == 2)
                else report_error($sformatf("hit took %0d cycles", wait_cycles));
        end
        if (!is_write) begin
            assert (mem_rdata == ref_mem[line])
                else report_error($sformatf("read %h gave %h, expected %h",
                                            addr, mem_rdata, ref_mem[line]));
        end
        if (is_write) begin
            ref_mem[line] = data;
        end
        ref_dirty[set][way] = is_write || (hit && ref_dirty[set][way]);
        ref_tag[set][way]   = tag;
        ref_valid[set][way] = 1'b1;
        ref_plru[set]       = plru_touch(ref_plru[set], way);
        @(negedge clk);   // let the response edge pass before the next request
    endtask

    initial begin
        int          set_sel;
        int          tag_sel;
        logic        is_write;
        logic [15:0] addr;
        reset       = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        for (int s = 0; s < 8; s++) begin
            ref_plru[s] = 7'd0;
            for (int w = 0; w < 8; w++) begin
                ref_tag[s][w]   = 9'd0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        assert (!mem_resp && !pmem_read && !pmem_write)
            else report_error("outputs not idle after reset");
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = i_mem.lines[a];   // initial memory contents
        end
        for (int op = 0; op < num_ops; op++) begin
            set_sel  = int'($unsigned($random(seed)) % 3);
            tag_sel  = int'($unsigned($random(seed)) % 12);
            is_write = 1'($unsigned($random(seed)) % 2);
            addr     = {9'(tag_sel * 41 + 5), 3'(set_sel * 3), 4'($unsigned($random(seed)))};
            run_access(is_write, addr,
                       {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
        $display("** PASS **");
        $finish;
    end

endmodule : l2_cache_tb

// File: verification/l2_mem_model.sv
module l2_mem_model (
    input  logic         clk,
    input  logic         pmem_read,
    input  logic         pmem_write,
    input  logic [15:0]  pmem_address,
    input  logic [127:0] pmem_wdata,
    output logic [127:0] pmem_rdata,
    output logic         pmem_resp
);

    logic [127:0] lines [4096];   // one entry per 16-byte line
    integer       seed = 74731;

    initial begin
        int          delay;
        logic [15:0] line_word;
        for (int a = 0; a < 4096; a++) begin
            line_word = 16'(a);
            lines[a]  = {4{line_word ^ 16'h5a00, ~line_word}};   // pattern of the line address
        end
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (pmem_read || pmem_write) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);   // 1 to 4 cycles
                repeat (delay - 1) @(negedge clk);
                if (pmem_write) begin
                    lines[pmem_address[15:4]] = pmem_wdata;
                end else begin
                    pmem_rdata = lines[pmem_address[15:4]];
                end
                pmem_resp = 1'b1;   // held over one rising edge
            end
        end
    end

endmodule : l2_mem_model

// File: source/l2_cache.sv
module l2_cache (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  l2_cache_pkg::lc3b_word      mem_address,
    input  l2_cache_pkg::lc3b_cacheline mem_wdata,
    output l2_cache_pkg::lc3b_cacheline mem_rdata,
    output logic                        mem_resp,
    output logic                        pmem_read,
    output logic                        pmem_write,
    output l2_cache_pkg::lc3b_word      pmem_address,
    output l2_cache_pkg::lc3b_cacheline pmem_wdata,
    input  l2_cache_pkg::lc3b_cacheline pmem_rdata,
    input  logic                        pmem_resp
);
    import l2_cache_pkg::*;
    import l2_ctl_pkg::*;

    lc3b_way_idx victim;
    lc3b_way_idx plru_way;
    logic        plru_update;

    l2_ctl_if ctl_if ();

    l2_cache_control i_control (
        .clk         (clk),
        .reset       (reset),
        .ctl         (ctl_if.ctl),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .pmem_resp   (pmem_resp),
        .victim      (victim),
        .mem_resp    (mem_resp),
        .pmem_read   (pmem_read),
        .pmem_write  (pmem_write),
        .plru_update (plru_update),
        .plru_way    (plru_way)
    );

    l2_cache_datapath i_datapath (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl_if.dp),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    l2_plru i_plru (
        .clk        (clk),
        .reset      (reset),
        .access_set (mem_address[offset_bits +: index_bits]),   // set of the held request
        .access_way (plru_way),
        .update     (plru_update),
        .victim     (victim)
    );

endmodule : l2_cache

// File: source/l2_cache_control.sv
module l2_cache_control (
    input  logic                    clk,
    input  logic                    reset,
    l2_ctl_if.ctl                   ctl,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  logic                    pmem_resp,
    input  l2_ctl_pkg::lc3b_way_idx victim,
    output logic                    mem_resp,
    output logic                    pmem_read,
    output logic                    pmem_write,
    output logic                    plru_update,
    output l2_ctl_pkg::lc3b_way_idx plru_way
);
    import l2_ctl_pkg::*;

    l2_state_e   state_q;
    l2_state_e   state_d;
    lc3b_way_idx way_q;   // way being served

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= s_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // hit way or victim captured at the compare
    always_ff @(posedge clk) begin
        if (state_q == s_compare) begin
            way_q <= ctl.way_sel;
        end
    end

    // the compare picks the hit way or the victim and later states keep it
    always_comb begin
        ctl.way_sel = way_q;
        if (state_q == s_compare) begin
            ctl.way_sel = ctl.hit ? ctl.hit_way : victim;
        end
    end

    always_comb begin
        state_d             = state_q;
        ctl.load_way        = '0;
        ctl.set_dirty       = 1'b0;
        ctl.fill_sel        = 1'b0;
        ctl.addr_sel_victim = 1'b0;
        case (state_q)
            s_idle: begin
                if (mem_read || mem_write) begin
                    state_d = s_compare;
                end
            end
            s_compare: begin
                if (ctl.hit) begin
                    if (mem_write) begin
                        ctl.load_way  = lc3b_way_mask'(1) << ctl.hit_way;   // write hit
                        ctl.set_dirty = 1'b1;
                    end
                    state_d = s_respond;
                end else begin
                    state_d = ctl.victim_dirty ? s_writeback : s_fill;
                end
            end
            s_writeback: begin
                ctl.addr_sel_victim = 1'b1;   // victim tag with the request set
                if (pmem_resp) begin
                    state_d = s_fill;
                end
            end
            s_fill: begin
                ctl.fill_sel = !mem_write;    // a write replaces the fetched line
                if (pmem_resp) begin
                    ctl.load_way  = lc3b_way_mask'(1) << way_q;
                    ctl.set_dirty = mem_write;
                    state_d       = s_respond;
                end
            end
            s_respond: begin
                state_d = s_idle;
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    assign mem_resp    = (state_q == s_respond);
    assign pmem_read   = (state_q == s_fill);
    assign pmem_write  = (state_q == s_writeback);
    assign plru_update = (state_q == s_respond);   // every response touches the tree
    assign plru_way    = way_q;

    // the upstream never reads and writes at once
    a_req_excl : assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

endmodule : l2_cache_control

// File: source/l2_cache_datapath.sv
module l2_cache_datapath (
    input  logic                        clk,
    input  logic                        reset,
    l2_ctl_if.dp                        ctl,
    input  l2_cache_pkg::lc3b_word      mem_address,
    input  l2_cache_pkg::lc3b_cacheline mem_wdata,
    input  l2_cache_pkg::lc3b_cacheline pmem_rdata,
    output l2_cache_pkg::lc3b_cacheline mem_rdata,
    output l2_cache_pkg::lc3b_word      pmem_address,
    output l2_cache_pkg::lc3b_cacheline pmem_wdata
);
    import l2_cache_pkg::*;
    import l2_ctl_pkg::*;

    lc3b_c_tag           req_tag;
    lc3b_c_index         req_index;
    lc3b_cacheline       fill_data;
    lc3b_cacheline       sel_line;
    lc3b_way_idx         hit_way_c;
    logic [num_ways-1:0] way_valid;
    logic [num_ways-1:0] way_dirty;
    logic [num_ways-1:0] hit_vec;
    lc3b_c_tag           way_tag  [num_ways];
    lc3b_cacheline       way_line [num_ways];

    assign req_tag   = mem_address[word_bits-1 -: tag_bits];
    assign req_index = mem_address[offset_bits +: index_bits];

    // whole-line writes, so the merge picks one source
    assign fill_data = ctl.fill_sel ? pmem_rdata : mem_wdata;

    for (genvar g = 0; g < num_ways; g++) begin : g_way
        l2_way i_way (
            .clk       (clk),
            .reset     (reset),
            .index     (req_index),
            .load      (ctl.load_way[g]),
            .set_dirty (ctl.set_dirty),
            .tag_in    (req_tag),
            .data_in   (fill_data),
            .valid     (way_valid[g]),
            .dirty     (way_dirty[g]),
            .tag_out   (way_tag[g]),
            .data_out  (way_line[g])
        );

        assign hit_vec[g] = way_valid[g] && (way_tag[g] == req_tag);
    end

    // encode the matching way
    always_comb begin
        hit_way_c = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way_c = lc3b_way_idx'(w);
            end
        end
    end

    assign ctl.hit          = |hit_vec;
    assign ctl.hit_way      = hit_way_c;
    assign ctl.victim_dirty = way_valid[ctl.way_sel] && way_dirty[ctl.way_sel];

    assign sel_line   = way_line[ctl.way_sel];
    assign mem_rdata  = sel_line;
    assign pmem_wdata = sel_line;   // write-back source

    assign pmem_address = ctl.addr_sel_victim ?
        {way_tag[ctl.way_sel], req_index, {offset_bits{1'b0}}} :
        {mem_address[word_bits-1:offset_bits], {offset_bits{1'b0}}};

    // a tag lives in at most one way of its set
    a_hit_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec));

endmodule : l2_cache_datapath

// File: source/l2_plru.sv
module l2_plru (
    input  logic                      clk,
    input  logic                      reset,
    input  l2_cache_pkg::lc3b_c_index access_set,
    input  l2_ctl_pkg::lc3b_way_idx   access_way,
    input  logic                      update,
    output l2_ctl_pkg::lc3b_way_idx   victim
);
    import l2_cache_pkg::*;
    import l2_ctl_pkg::*;

    lc3b_plru plru_q [num_sets];

    // walk from the root where a 0 bit goes to the lower half
    function automatic lc3b_way_idx pick_victim(lc3b_plru bits);
        int          node;
        logic        dir;
        lc3b_way_idx way;
        node = 0;
        way  = '0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            dir  = bits[node];
            way  = {way[way_bits-2:0], dir};
            node = 2 * node + 1 + int'(dir);   // children of k are 2k+1 and 2k+2
        end
        return way;
    endfunction

    // every node on the path turns away from the way just used
    function automatic lc3b_plru touch(lc3b_plru bits, lc3b_way_idx way);
        int       node;
        logic     dir;
        lc3b_plru next;
        node = 0;
        next = bits;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            dir        = way[way_bits-1-lvl];
            next[node] = ~dir;
            node       = 2 * node + 1 + int'(dir);
        end
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                plru_q[s] <= '0;
            end
        end else if (update) begin
            plru_q[access_set] <= touch(plru_q[access_set], access_way);
        end
    end

    assign victim = pick_victim(plru_q[access_set]);

    // a served way must be known when the tree is updated
    a_way_known : assert property (@(posedge clk) disable iff (reset)
        update |-> !$isunknown(access_way));

endmodule : l2_plru

// File: source/l2_way.sv
module l2_way (
    input  logic                        clk,
    input  logic                        reset,
    input  l2_cache_pkg::lc3b_c_index   index,
    input  logic                        load,
    input  logic                        set_dirty,
    input  l2_cache_pkg::lc3b_c_tag     tag_in,
    input  l2_cache_pkg::lc3b_cacheline data_in,
    output logic                        valid,
    output logic                        dirty,
    output l2_cache_pkg::lc3b_c_tag     tag_out,
    output l2_cache_pkg::lc3b_cacheline data_out
);
    import l2_cache_pkg::*;

    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;
    lc3b_c_tag           tag_q  [num_sets];
    lc3b_cacheline       data_q [num_sets];

    // status bits per set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (load) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= set_dirty;
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (load) begin
            tag_q[index]  <= tag_in;
            data_q[index] <= data_in;
        end
    end

    assign valid    = valid_q[index];
    assign dirty    = dirty_q[index];
    assign tag_out  = tag_q[index];
    assign data_out = data_q[index];

endmodule : l2_way

// File: source/l2_ctl_if.sv
interface l2_ctl_if;
    import l2_ctl_pkg::*;

    // controller to datapath
    lc3b_way_mask load_way;          // write enable per way
    logic         set_dirty;         // dirty value written with a load
    logic         fill_sel;          // 1 = memory line, 0 = upstream line
    logic         addr_sel_victim;   // 1 = victim tag address
    lc3b_way_idx  way_sel;           // way read out upstream and to memory

    // datapath to controller
    logic         hit;
    lc3b_way_idx  hit_way;
    logic         victim_dirty;      // way_sel holds a valid dirty line

    modport ctl (
        output load_way, set_dirty, fill_sel, addr_sel_victim, way_sel,
        input  hit, hit_way, victim_dirty
    );

    modport dp (
        input  load_way, set_dirty, fill_sel, addr_sel_victim, way_sel,
        output hit, hit_way, victim_dirty
    );

endinterface : l2_ctl_if

// File: source/l2_ctl_pkg.sv
package l2_ctl_pkg;

    localparam int way_bits = $clog2(l2_cache_pkg::num_ways);   // also the tree depth

    // miss sequencing of the controller
    typedef enum logic [2:0] {
        s_idle,
        s_compare,
        s_writeback,
        s_fill,
        s_respond
    } l2_state_e;

    typedef logic [way_bits-1:0]              lc3b_way_idx;    // way number
    typedef logic [l2_cache_pkg::num_ways-1:0] lc3b_way_mask;   // one bit per way

endpackage : l2_ctl_pkg

// File: source/l2_cache_pkg.sv
package l2_cache_pkg;

    // cache geometry
    localparam int num_ways    = 8;
    localparam int num_sets    = 8;
    localparam int word_bits   = 16;
    localparam int line_bits   = 128;
    localparam int offset_bits = 4;   // 16 bytes per line
    localparam int index_bits  = 3;
    localparam int tag_bits    = word_bits - index_bits - offset_bits;
    localparam int plru_bits   = num_ways - 1;   // one bit per tree node

    typedef logic [word_bits-1:0]   lc3b_word;        // byte address
    typedef logic [tag_bits-1:0]    lc3b_c_tag;
    typedef logic [index_bits-1:0]  lc3b_c_index;
    typedef logic [line_bits-1:0]   lc3b_cacheline;
    typedef logic [plru_bits-1:0]   lc3b_plru;        // tree bits of one set

endpackage : l2_cache_pkg
